//--- async_fifo.f
rtl/fifo_geom_pkg.sv
rtl/fifo_ptr_pkg.sv
rtl/gray_ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/fifo_dpram.sv
rtl/async_fifo.sv
testbench/async_fifo_tb.sv

//--- rtl/async_fifo.sv
`timescale 1ns/10ps

module async_fifo (
	// Write domain
	input  logic                                 wr_clk,
	input  logic                                 wr_rst,
	input  logic                                 wr_en,
	input  logic [fifo_geom_pkg::data_width-1:0] din,
	output logic                                 full,
	// Read domain
	input  logic                                 rd_clk,
	input  logic                                 rd_rst,
	input  logic                                 rd_en,
	output logic [fifo_geom_pkg::data_width-1:0] dout,
	output logic                                 empty
);

	logic                                 wr_accept;
	logic                                 rd_accept;
	logic [fifo_geom_pkg::addr_width-1:0] waddr;
	logic [fifo_geom_pkg::addr_width-1:0] raddr;
	// Gray pointers, native and synced copies
	logic [fifo_ptr_pkg::ptr_width-1:0]  wr_gray;
	logic [fifo_ptr_pkg::ptr_width-1:0]  rd_gray;
	logic [fifo_ptr_pkg::ptr_width-1:0]  wr_gray_rd;
	logic [fifo_ptr_pkg::ptr_width-1:0]  rd_gray_wr;

	// Write side pointers and full flag
	fifo_wr_ctrl u_wr_ctrl (
		.wr_clk     (wr_clk),
		.wr_rst     (wr_rst),
		.wr_en      (wr_en),
		.rd_gray_wr (rd_gray_wr),
		.full       (full),
		.wr_accept  (wr_accept),
		.waddr      (waddr),
		.wr_gray    (wr_gray)
	);

	// Read side pointers and empty flag
	fifo_rd_ctrl u_rd_ctrl (
		.rd_clk     (rd_clk),
		.rd_rst     (rd_rst),
		.rd_en      (rd_en),
		.wr_gray_rd (wr_gray_rd),
		.empty      (empty),
		.rd_accept  (rd_accept),
		.raddr      (raddr),
		.rd_gray    (rd_gray)
	);

	//----------------------------------------------------------------------
	// Pointer crossings
	//----------------------------------------------------------------------

	// Write pointer into rd_clk
	gray_ptr_sync u_wr_to_rd (
		.clk     (rd_clk),
		.rst     (rd_rst),
		.ptr_in  (wr_gray),
		.ptr_out (wr_gray_rd)
	);

	// Read pointer into wr_clk
	gray_ptr_sync u_rd_to_wr (
		.clk     (wr_clk),
		.rst     (wr_rst),
		.ptr_in  (rd_gray),
		.ptr_out (rd_gray_wr)
	);

	// Storage
	fifo_dpram u_dpram (
		.wr_clk    (wr_clk),
		.wr_accept (wr_accept),
		.waddr     (waddr),
		.din       (din),
		.rd_clk    (rd_clk),
		.rd_rst    (rd_rst),
		.rd_accept (rd_accept),
		.raddr     (raddr),
		.dout      (dout)
	);

endmodule

//--- rtl/fifo_dpram.sv
`timescale 1ns/10ps

module fifo_dpram (
	// Write port
	input  logic                                 wr_clk,
	input  logic                                 wr_accept,
	input  logic [fifo_geom_pkg::addr_width-1:0] waddr,
	input  logic [fifo_geom_pkg::data_width-1:0] din,
	// Read port
	input  logic                                 rd_clk,
	input  logic                                 rd_rst,
	input  logic                                 rd_accept,
	input  logic [fifo_geom_pkg::addr_width-1:0] raddr,
	output logic [fifo_geom_pkg::data_width-1:0] dout
);

	//----------------------------------------------------------------------
	// Storage array
	//----------------------------------------------------------------------

	logic [fifo_geom_pkg::data_width-1:0] mem [fifo_geom_pkg::depth];

	// Write side, only accepted bytes land
	always_ff @(posedge wr_clk)
	begin
		if (wr_accept)
			mem[waddr] <= din;
	end

	//----------------------------------------------------------------------
	// Registered read port
	//----------------------------------------------------------------------

	// Byte appears on dout the edge after the read is accepted
	// Holds its value between reads
	always_ff @(posedge rd_clk or posedge rd_rst)
	begin
		if (rd_rst)
			dout <= '0;
		else if (rd_accept)
			dout <= mem[raddr];
	end

endmodule

//--- rtl/fifo_geom_pkg.sv
package fifo_geom_pkg;

	//----------------------------------------------------------------------
	// Storage geometry
	//----------------------------------------------------------------------

	// Bits per stored entry
	localparam int data_width = 8;

	// Address bits into the storage array
	localparam int addr_width = 4;

	// Entry count, always a power of two
	// Pointer wrap logic relies on this
	localparam int depth = 1 << addr_width;

endpackage

//--- rtl/fifo_ptr_pkg.sv
package fifo_ptr_pkg;

	//----------------------------------------------------------------------
	// Pointer geometry
	//----------------------------------------------------------------------

	// Address bits plus one wrap bit
	// Wrap bit tells full apart from empty
	localparam int ptr_width = fifo_geom_pkg::addr_width + 1;

	// Flops per clock domain crossing
	localparam int sync_stages = 2;

	//----------------------------------------------------------------------
	// Gray code conversion
	//----------------------------------------------------------------------

	// Binary to Gray, one bit changes per increment
	function automatic logic [ptr_width-1:0] bin_to_gray(input logic [ptr_width-1:0] bin);
		return (bin >> 1) ^ bin;
	endfunction

	// Gray back to binary
	// Each bit is the XOR of all Gray bits at and above it
	function automatic logic [ptr_width-1:0] gray_to_bin(input logic [ptr_width-1:0] gray);
		logic [ptr_width-1:0] bin;
		bin[ptr_width-1] = gray[ptr_width-1];
		for (int i = ptr_width - 2; i >= 0; i--)
		begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

//--- rtl/fifo_rd_ctrl.sv
`timescale 1ns/10ps

module fifo_rd_ctrl (
	input  logic                                 rd_clk,
	input  logic                                 rd_rst,
	input  logic                                 rd_en,
	input  logic [fifo_ptr_pkg::ptr_width-1:0]  wr_gray_rd,
	output logic                                 empty,
	output logic                                 rd_accept,
	output logic [fifo_geom_pkg::addr_width-1:0] raddr,
	output logic [fifo_ptr_pkg::ptr_width-1:0]  rd_gray
);

	localparam int pw = fifo_ptr_pkg::ptr_width;

	logic [pw-1:0] rbin;
	logic [pw-1:0] rbin_next;
	logic [pw-1:0] rgray_next;
	logic          empty_next;
	// Occupancy as seen from the read side, for checking only
	logic [pw-1:0] rd_fill;

	// Read strobe is ignored while empty
	assign rd_accept = rd_en && !empty;

	// Next pointers
	assign rbin_next  = rbin + pw'(rd_accept);
	assign rgray_next = fifo_ptr_pkg::bin_to_gray(rbin_next);

	// Array read address
	assign raddr = rbin[fifo_geom_pkg::addr_width-1:0];

	//----------------------------------------------------------------------
	// Empty test
	//----------------------------------------------------------------------

	// Empty once the next read pointer catches the synced write pointer
	assign empty_next = (rgray_next == wr_gray_rd);

	always_ff @(posedge rd_clk or posedge rd_rst)
	begin
		if (rd_rst)
		begin
			rbin    <= '0;
			rd_gray <= '0;
			// Nothing stored out of reset
			empty   <= 1'b1;
		end
		else
		begin
			rbin    <= rbin_next;
			rd_gray <= rgray_next;
			empty   <= empty_next;
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	assign rd_fill = fifo_ptr_pkg::gray_to_bin(wr_gray_rd) - rbin;

	// Read pointer never passes the synced write pointer
	// A wrapped negative distance would show up as a value above depth
	a_no_underflow: assert property (@(posedge rd_clk) disable iff (rd_rst)
		rd_fill <= pw'(fifo_geom_pkg::depth));

endmodule

//--- rtl/fifo_wr_ctrl.sv
`timescale 1ns/10ps

module fifo_wr_ctrl (
	input  logic                                 wr_clk,
	input  logic                                 wr_rst,
	input  logic                                 wr_en,
	input  logic [fifo_ptr_pkg::ptr_width-1:0]  rd_gray_wr,
	output logic                                 full,
	output logic                                 wr_accept,
	output logic [fifo_geom_pkg::addr_width-1:0] waddr,
	output logic [fifo_ptr_pkg::ptr_width-1:0]  wr_gray
);

	localparam int pw = fifo_ptr_pkg::ptr_width;

	logic [pw-1:0] wbin;
	logic [pw-1:0] wbin_next;
	logic [pw-1:0] wgray_next;
	logic          full_next;
	// Occupancy as seen from the write side, for checking only
	logic [pw-1:0] wr_fill;

	// Write strobe is dropped while full
	assign wr_accept = wr_en && !full;

	// Next pointers
	assign wbin_next  = wbin + pw'(wr_accept);
	assign wgray_next = fifo_ptr_pkg::bin_to_gray(wbin_next);

	// Binary pointer addresses the array directly
	assign waddr = wbin[fifo_geom_pkg::addr_width-1:0];

	//----------------------------------------------------------------------
	// Full test
	//----------------------------------------------------------------------

	// Full when the next write pointer is one lap ahead of the read pointer
	// In Gray code that means the two top bits differ and the rest match
	assign full_next = (wgray_next == {~rd_gray_wr[pw-1:pw-2], rd_gray_wr[pw-3:0]});

	always_ff @(posedge wr_clk or posedge wr_rst)
	begin
		if (wr_rst)
		begin
			wbin    <= '0;
			wr_gray <= '0;
			full    <= 1'b0;
		end
		else
		begin
			wbin    <= wbin_next;
			wr_gray <= wgray_next;
			full    <= full_next;
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	assign wr_fill = wbin - fifo_ptr_pkg::gray_to_bin(rd_gray_wr);

	// Write pointer never gets more than depth ahead of the synced read pointer
	// So no write is ever accepted into a full FIFO
	a_no_overflow: assert property (@(posedge wr_clk) disable iff (wr_rst)
		wr_fill <= pw'(fifo_geom_pkg::depth));

endmodule

//--- rtl/gray_ptr_sync.sv
`timescale 1ns/10ps

module gray_ptr_sync (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [fifo_ptr_pkg::ptr_width-1:0] ptr_in,
	output logic [fifo_ptr_pkg::ptr_width-1:0] ptr_out
);

	// Flop chain, stage 0 is the metastable one
	logic [fifo_ptr_pkg::ptr_width-1:0] stage_q [fifo_ptr_pkg::sync_stages];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < fifo_ptr_pkg::sync_stages; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= ptr_in;
			// Shift toward the output
			for (int i = 1; i < fifo_ptr_pkg::sync_stages; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	// Last stage is safe to use in this domain
	assign ptr_out = stage_q[fifo_ptr_pkg::sync_stages-1];

	// Source pointer must move one Gray step at a time
	// Clocked on the input itself, sampled values trail by one change
	// so this compares each value with the one before it
	a_gray_step: assert property (@(ptr_in) disable iff (rst)
		$countones(ptr_in ^ $past(ptr_in)) <= 1);

endmodule

//--- testbench/async_fifo_tb.sv
`timescale 1ns/10ps

module async_fifo_tb;

	//----------------------------------------------------------------------
	// Constants
	//----------------------------------------------------------------------

	localparam int rd_half = 5;
	localparam int wr_half = 7;
	localparam logic [31:0] seed = 32'h460a;
	// Test lengths in rd_clk cycles
	localparam int len_reset   = 4;
	localparam int len_order   = 20;
	localparam int len_full    = 100;
	localparam int len_empty   = 20;
	localparam int len_traffic = 300;
	localparam int len_drain   = 60;
	localparam int timeout_cycles =
		4 * (len_reset + len_order + len_full + len_empty + len_traffic + len_drain);
	// Writer cycles that span the same time as the reader's
	localparam int wr_traffic = len_traffic * rd_half / wr_half;
	// Age after which a flag must agree with the model
	localparam realtime settle_rd = 5 * 2 * rd_half;
	localparam realtime settle_wr = 5 * 2 * wr_half;

	logic wr_clk = 1'b0;
	logic rd_clk = 1'b0;
	logic wr_rst;
	logic rd_rst;
	logic wr_en;
	logic rd_en;
	logic [fifo_geom_pkg::data_width-1:0] din;
	logic [fifo_geom_pkg::data_width-1:0] dout;
	logic full;
	logic empty;

	// Reference model, bytes and their write times
	logic [fifo_geom_pkg::data_width-1:0] model_q [$];
	realtime write_time_q [$];
	realtime last_pop_time;
	logic [fifo_geom_pkg::data_width-1:0] exp_dout;
	// Flag expectations, each valid at the following edge
	logic full_due;
	logic full_stale;
	logic empty_due;
	logic empty_stale;
	logic check_reset;

	logic [31:0] lfsr;
	int errors;
	int test_errors_base;
	int tests_run;
	int tests_failed;
	int cycle_count;

	async_fifo u_dut (
		.wr_clk (wr_clk),
		.wr_rst (wr_rst),
		.wr_en  (wr_en),
		.din    (din),
		.full   (full),
		.rd_clk (rd_clk),
		.rd_rst (rd_rst),
		.rd_en  (rd_en),
		.dout   (dout),
		.empty  (empty)
	);

	// Two unrelated clocks, phase drifts between them
	always #rd_half rd_clk = ~rd_clk;
	always #wr_half wr_clk = ~wr_clk;

	//----------------------------------------------------------------------
	// Random source
	//----------------------------------------------------------------------

	// Galois LFSR, one step per bit
	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
		return b;
	endfunction

	function automatic logic [7:0] take_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], take_bit()};
		return v;
	endfunction

	//----------------------------------------------------------------------
	// Reference model
	//----------------------------------------------------------------------

	// Write side, same acceptance rule as the FIFO
	always @(posedge wr_clk or posedge wr_rst)
	begin
		if (wr_rst)
		begin
			model_q.delete();
			write_time_q.delete();
			full_due   <= 1'b0;
			full_stale <= 1'b0;
		end
		else
		begin
			if (wr_en && !full)
			begin
				model_q.push_back(din);
				write_time_q.push_back($realtime);
			end
			full_due   <= (model_q.size() >= fifo_geom_pkg::depth);
			// No read for a while, so full must match the model
			full_stale <= (model_q.size() < fifo_geom_pkg::depth) &&
				($realtime - last_pop_time > settle_wr);
		end
	end

	// Read side, pops into the expected dout
	always @(posedge rd_clk or posedge rd_rst)
	begin
		if (rd_rst)
		begin
			exp_dout    <= '0;
			empty_due   <= 1'b0;
			empty_stale <= 1'b0;
			last_pop_time = 0.0;
		end
		else
		begin
			if (rd_en && !empty)
			begin
				if (model_q.size() == 0)
				begin
					errors++;
					$display("Read accepted at %0t while the reference queue was empty",
						$realtime);
				end
				else
				begin
					exp_dout <= model_q.pop_front();
					write_time_q.delete(0);
				end
				last_pop_time = $realtime;
			end
			empty_due <= (model_q.size() == 0);
			// Oldest byte long since synced, so empty must be low
			empty_stale <= (model_q.size() != 0) ?
				($realtime - write_time_q[0] > settle_rd) : 1'b0;
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	a_reset_state: assert property (@(posedge rd_clk) disable iff (rd_rst)
		check_reset |-> (empty && !full && dout == '0))
	else
	begin
		errors++;
		$display("FAILED %0t empty/full/dout expected 1/0/00 got %b/%b/%h", $realtime,
			$sampled(empty), $sampled(full), $sampled(dout));
	end

	// Covers ordering, read latency and the hold while empty
	a_dout: assert property (@(posedge rd_clk) disable iff (rd_rst)
		dout == exp_dout)
	else
	begin
		errors++;
		$display("FAILED %0t dout expected %h got %h", $realtime,
			$sampled(exp_dout), $sampled(dout));
	end

	a_full_due: assert property (@(posedge wr_clk) disable iff (wr_rst)
		full_due |-> full)
	else
	begin
		errors++;
		$display("FAILED %0t full expected 1 got %b", $realtime, $sampled(full));
	end

	a_full_stale: assert property (@(posedge wr_clk) disable iff (wr_rst)
		full_stale |-> !full)
	else
	begin
		errors++;
		$display("FAILED %0t full expected 0 got %b", $realtime, $sampled(full));
	end

	a_empty_due: assert property (@(posedge rd_clk) disable iff (rd_rst)
		empty_due |-> empty)
	else
	begin
		errors++;
		$display("FAILED %0t empty expected 1 got %b", $realtime, $sampled(empty));
	end

	a_empty_stale: assert property (@(posedge rd_clk) disable iff (rd_rst)
		empty_stale |-> !empty)
	else
	begin
		errors++;
		$display("FAILED %0t empty expected 0 got %b", $realtime, $sampled(empty));
	end

	// Hang guard
	always @(posedge rd_clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d rd_clk cycles",
				timeout_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic begin_test();
		test_errors_base = errors;
	endtask

	task automatic end_test(input string name);
		@(negedge rd_clk);
		tests_run++;
		if (errors == test_errors_base)
			$display("Test %0d (%s) finished clean", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d (%s) finished with %0d errors", tests_run, name,
				errors - test_errors_base);
		end
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------

	initial
	begin
		lfsr = seed;
		wr_rst = 1'b1;
		rd_rst = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		din = '0;
		check_reset = 1'b0;
		repeat (2) @(posedge rd_clk);
		wr_rst <= 1'b0;
		rd_rst <= 1'b0;

		// Reset state
		begin_test();
		@(posedge rd_clk);
		check_reset <= 1'b1;
		@(posedge rd_clk);
		check_reset <= 1'b0;
		@(posedge rd_clk);
		end_test("reset state");

		// One byte through an empty FIFO
		begin_test();
		@(posedge wr_clk);
		wr_en <= 1'b1;
		din   <= take_byte();
		@(posedge wr_clk);
		wr_en <= 1'b0;
		@(posedge rd_clk);
		while (empty)
			@(posedge rd_clk);
		rd_en <= 1'b1;
		@(posedge rd_clk);
		rd_en <= 1'b0;
		repeat (3) @(posedge rd_clk);
		end_test("ordering");

		// Overfill, four extra writes get dropped
		begin_test();
		repeat (fifo_geom_pkg::depth + 4)
		begin
			@(posedge wr_clk);
			wr_en <= 1'b1;
			din   <= take_byte();
		end
		@(posedge wr_clk);
		wr_en <= 1'b0;
		repeat (4) @(posedge rd_clk);
		rd_en <= 1'b1;
		while (model_q.size() != 0)
			@(posedge rd_clk);
		repeat (2) @(posedge rd_clk);
		end_test("full and overflow");

		// Reads keep coming while empty
		begin_test();
		repeat (8) @(posedge rd_clk);
		rd_en <= 1'b0;
		repeat (2) @(posedge rd_clk);
		end_test("empty and underflow");

		// Random traffic on both sides at once
		begin_test();
		fork
			begin
				repeat (len_traffic)
				begin
					@(posedge rd_clk);
					rd_en <= take_bit();
				end
				@(posedge rd_clk);
				rd_en <= 1'b0;
			end
			begin
				repeat (wr_traffic)
				begin
					@(posedge wr_clk);
					wr_en <= take_bit();
					din   <= take_byte();
				end
				@(posedge wr_clk);
				wr_en <= 1'b0;
			end
		join
		// Drain what is left
		@(posedge rd_clk);
		rd_en <= 1'b1;
		while (model_q.size() != 0)
			@(posedge rd_clk);
		repeat (3) @(posedge rd_clk);
		rd_en <= 1'b0;
		repeat (3) @(posedge rd_clk);
		end_test("concurrent traffic");

		$display("Tests run %0d, clean %0d, with errors %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
